//--- source/rng_pkg.sv
// Shared widths, register map, AXI response codes and generator constants
`default_nettype none

package rng_pkg;

    // Data bus, generator state and register contents
    parameter int data_width = 8;

    // Register map, compared against the full address
    parameter int unsigned addr_rand = 32'h0;
    parameter int unsigned addr_ctrl = 32'h1;

    // AXI response codes
    parameter logic [1:0] resp_okay   = 2'b00;
    parameter logic [1:0] resp_slverr = 2'b10;

    // Generator state after reset
    parameter logic [data_width-1:0] rand_reset = 8'h55;

    // CTRL after reset: bit 0 enable, bit 1 mode
    // Enabled, toggle mode
    parameter logic [1:0] ctrl_reset = 2'b01;

    // Galois feedback mask
    // Maximal length for 8 bits
    parameter logic [data_width-1:0] lfsr_taps = 8'hB8;

endpackage

`default_nettype wire

//--- source/axil_slave_port.sv
// AXI4-Lite slave port with joined AW/W handshake, B and R response registers
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port
    import rng_pkg::*;
#(
    parameter int addr_width = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    // Write address channel
    input  logic [addr_width-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,

    // Write data channel
    input  logic [data_width-1:0] s_axi_wdata,
    input  logic [0:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,

    // Write response channel
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    // Read address channel
    input  logic [addr_width-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,

    // Read data channel
    output logic [data_width-1:0] s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    // Register bank side
    output logic                  wr_en,
    output logic [addr_width-1:0] wr_addr,
    output logic [data_width-1:0] wr_data,
    output logic                  wr_strb,
    input  logic                  wr_err,
    output logic                  rd_en,
    output logic [addr_width-1:0] rd_addr,
    input  logic [data_width-1:0] rd_data,
    input  logic                  rd_err
);

    // AW and W always open and close together, so one flag serves both
    logic                  wr_ready_q;
    logic                  bvalid_q;
    logic [1:0]            bresp_q;
    logic                  arready_q;
    logic                  rvalid_q;
    logic [data_width-1:0] rdata_q;
    logic [1:0]            rresp_q;

    logic                  wr_hs;
    logic                  b_hs;
    logic                  rd_hs;
    logic                  r_hs;

    // Handshakes
    assign wr_hs = s_axi_awvalid & s_axi_wvalid & wr_ready_q;
    assign b_hs  = bvalid_q & s_axi_bready;
    assign rd_hs = s_axi_arvalid & arready_q;
    assign r_hs  = rvalid_q & s_axi_rready;

    // Single-cycle strobes toward the register bank
    assign wr_en   = wr_hs;
    assign wr_addr = s_axi_awaddr;
    assign wr_data = s_axi_wdata;
    assign wr_strb = s_axi_wstrb[0];
    assign rd_en   = rd_hs;
    assign rd_addr = s_axi_araddr;

    // Channel outputs
    assign s_axi_awready = wr_ready_q;
    assign s_axi_wready  = wr_ready_q;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_bresp   = bresp_q;
    assign s_axi_arready = arready_q;
    assign s_axi_rvalid  = rvalid_q;
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = rresp_q;

    // Write side flags, one write outstanding
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ready_q <= 1'b1;
            bvalid_q   <= 1'b0;
        end else if (wr_hs) begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b1;
        end else if (b_hs) begin
            wr_ready_q <= 1'b1;
            bvalid_q   <= 1'b0;
        end
    end

    // Write response, held until B is accepted
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp_q <= wr_err ? resp_slverr : resp_okay;
        end
    end

    // Read side flags, one read outstanding
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready_q <= 1'b1;
            rvalid_q  <= 1'b0;
        end else if (rd_hs) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;
        end else if (r_hs) begin
            arready_q <= 1'b1;
            rvalid_q  <= 1'b0;
        end
    end

    // Read data sampled at the AR handshake edge
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_err ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

//--- source/rng_regs.sv
// Register bank: address decode, CTRL register, read mux and error flags
`timescale 1ns/1ps
`default_nettype none

module rng_regs
    import rng_pkg::*;
#(
    parameter int addr_width = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    // From the slave port
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    input  logic                  wr_strb,
    output logic                  wr_err,
    input  logic                  rd_en,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data,
    output logic                  rd_err,

    // Toward the generator core
    output logic                  load,
    output logic [data_width-1:0] load_value,
    output logic                  hold,
    output logic                  enable,
    output logic                  mode,
    input  logic [data_width-1:0] state
);

    // Map addresses sized to the bus, upper bits must be zero to hit
    localparam logic [addr_width-1:0] rand_addr = addr_width'(addr_rand);
    localparam logic [addr_width-1:0] ctrl_addr = addr_width'(addr_ctrl);

    logic [1:0] ctrl_q;
    logic       wr_hit_rand;
    logic       wr_hit_ctrl;
    logic       rd_hit_rand;
    logic       rd_hit_ctrl;

    // Decode
    assign wr_hit_rand = (wr_addr == rand_addr);
    assign wr_hit_ctrl = (wr_addr == ctrl_addr);
    assign rd_hit_rand = (rd_addr == rand_addr);
    assign rd_hit_ctrl = (rd_addr == ctrl_addr);

    // Unmapped accesses answer SLVERR
    assign wr_err = wr_en & ~(wr_hit_rand | wr_hit_ctrl);
    assign rd_err = rd_en & ~(rd_hit_rand | rd_hit_ctrl);

    // Seed load on a strobed RAND write
    // Every other write freezes the generator for that cycle
    assign load       = wr_en & wr_hit_rand & wr_strb;
    assign load_value = wr_data;
    assign hold       = wr_en & ~load;

    // CTRL fields
    assign enable = ctrl_q[0];
    assign mode   = ctrl_q[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q <= ctrl_reset;
        end else if (wr_en && wr_hit_ctrl && wr_strb) begin
            ctrl_q <= wr_data[1:0];
        end
    end

    // Read mux, zero for unmapped
    always_comb begin
        rd_data = '0;
        if (rd_hit_rand) begin
            rd_data = state;
        end else if (rd_hit_ctrl) begin
            rd_data = {{(data_width-2){1'b0}}, ctrl_q};
        end
    end

endmodule

`default_nettype wire

//--- source/rng_core.sv
// Generator core: state register with load, hold, toggle step and Galois LFSR step
`timescale 1ns/1ps
`default_nettype none

module rng_core
    import rng_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  logic [data_width-1:0] load_value,
    input  logic                  hold,
    input  logic                  enable,
    input  logic                  mode,
    output logic [data_width-1:0] state
);

    logic [data_width-1:0] state_q;
    logic [data_width-1:0] toggle_next;
    logic [data_width-1:0] lfsr_next;
    logic [data_width-1:0] step_next;

    // Toggle mode flips bit 0 only
    assign toggle_next = state_q ^ {{(data_width-1){1'b0}}, 1'b1};

    // Galois step, shift right and fold in the taps on a set LSB
    always_comb begin
        if (state_q == '0) begin
            // Zero would lock up the LFSR
            lfsr_next = {{(data_width-1){1'b0}}, 1'b1};
        end else if (state_q[0]) begin
            lfsr_next = (state_q >> 1) ^ lfsr_taps;
        end else begin
            lfsr_next = state_q >> 1;
        end
    end

    assign step_next = mode ? lfsr_next : toggle_next;

    // Priority: load, then hold or disabled, then step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= rand_reset;
        end else if (load) begin
            state_q <= load_value;
        end else if (!hold && enable) begin
            state_q <= step_next;
        end
    end

    assign state = state_q;

endmodule

`default_nettype wire

//--- source/rng_axil_top.sv
// Top level of the AXI4-Lite random value generator: port, register bank and core
`timescale 1ns/1ps
`default_nettype none

module rng_axil_top
    import rng_pkg::*;
#(
    parameter int addr_width = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    // Write address channel
    input  logic [addr_width-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,

    // Write data channel
    input  logic [data_width-1:0] s_axi_wdata,
    input  logic [0:0]            s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,

    // Write response channel
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    // Read address channel
    input  logic [addr_width-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,

    // Read data channel
    output logic [data_width-1:0] s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready
);

    // Port to register bank
    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic                  wr_strb;
    logic                  wr_err;
    logic                  rd_en;
    logic [addr_width-1:0] rd_addr;
    logic [data_width-1:0] rd_data;
    logic                  rd_err;

    // Register bank to core
    logic                  load;
    logic [data_width-1:0] load_value;
    logic                  hold;
    logic                  enable;
    logic                  mode;
    logic [data_width-1:0] state;

    axil_slave_port #(
        .addr_width (addr_width)
    ) port_i (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .wr_err        (wr_err),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_err        (rd_err)
    );

    rng_regs #(
        .addr_width (addr_width)
    ) regs_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .wr_err     (wr_err),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_err     (rd_err),
        .load       (load),
        .load_value (load_value),
        .hold       (hold),
        .enable     (enable),
        .mode       (mode),
        .state      (state)
    );

    rng_core core_i (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .load_value (load_value),
        .hold       (hold),
        .enable     (enable),
        .mode       (mode),
        .state      (state)
    );

endmodule

`default_nettype wire

//--- bench/rng_tb_assert.sv
// Bound concurrent checks on the B and R channels of the AXI4-Lite slave port
`timescale 1ns/1ps
`default_nettype none

module rng_tb_assert
    import rng_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  s_axi_awready,
    input logic                  s_axi_wready,
    input logic [1:0]            s_axi_bresp,
    input logic                  s_axi_bvalid,
    input logic                  s_axi_bready,
    input logic                  s_axi_arready,
    input logic [data_width-1:0] s_axi_rdata,
    input logic [1:0]            s_axi_rresp,
    input logic                  s_axi_rvalid,
    input logic                  s_axi_rready
);

    // A response waits, unchanged, until the master takes it
    b_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else $error("B response dropped or changed before bready");

    r_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready
        |=> s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
        else $error("R response dropped or changed before rready");

    // One outstanding request per direction
    b_blocks: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid |-> !s_axi_awready && !s_axi_wready)
        else $error("Write channel ready while B response pending");

    r_blocks: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid |-> !s_axi_arready)
        else $error("Read address ready while R response pending");

    // No stale responses out of reset
    rst_quiet: assert property (@(posedge clk)
        rst || $fell(rst) |-> !s_axi_bvalid && !s_axi_rvalid)
        else $error("Response valid during or right after reset");

endmodule

`default_nettype wire

//--- bench/rng_tb.sv
// Testbench: clock, reset, directed and random AXI4-Lite traffic, reference model, checks
`timescale 1ns/1ps
`default_nettype none

module rng_tb;

    localparam int addr_w     = 4;
    localparam int wait_limit = 200;
    localparam int rand_ops   = 80;

    // Reset values, feedback mask and response codes
    localparam logic [7:0] state_init = 8'h55;
    localparam logic [1:0] ctrl_init  = 2'b01;
    localparam logic [7:0] taps       = 8'hB8;
    localparam logic [1:0] okay       = 2'b00;
    localparam logic [1:0] slverr     = 2'b10;

    logic              clk;
    logic              rst;
    logic [addr_w-1:0] s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [7:0]        s_axi_wdata;
    logic [0:0]        s_axi_wstrb;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [addr_w-1:0] s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [7:0]        s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rvalid;
    logic              s_axi_rready;

    integer seed = 16;

    // Reference model and responses still owed by the DUT
    logic [7:0] model_state;
    logic [1:0] model_ctrl;
    logic [1:0] exp_bresp[$];
    logic [7:0] exp_rdata[$];
    logic [1:0] exp_rresp[$];

    int                streams_done;
    int                wr_count;
    int                rd_count;
    int                bp_cycles;
    logic [7:0]        rd_val;
    logic [7:0]        bp_byte;
    logic [7:0]        wr_byte;
    logic [7:0]        wr_val;
    logic [addr_w-1:0] wr_pick;
    logic [addr_w-1:0] rd_pick;

    rng_axil_top #(
        .addr_width (addr_w)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    bind axil_slave_port rng_tb_assert assert_i (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awready (s_axi_awready),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] expected);
        $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, expected);
        $display("Test failures found");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Mostly mapped registers with an occasional hole in the map
    function automatic logic [addr_w-1:0] pick_addr();
        logic [7:0] r;
        r = rand_byte();
        if (r[2:0] < 3'd3) return 4'h0;
        if (r[2:0] < 3'd6) return 4'h1;
        return (r[7:4] < 4'h2) ? r[7:4] + 4'h2 : r[7:4];
    endfunction

    function automatic logic [7:0] galois_step(input logic [7:0] v);
        if (v == 8'h00) return 8'h01;
        if (v[0]) return (v >> 1) ^ taps;
        return v >> 1;
    endfunction

    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [7:0] data,
                             input logic strb);
        int waited;
        @(posedge clk);
        #1;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_error("write address and data never accepted");
        end while (!(s_axi_awready && s_axi_wready));
        @(posedge clk);
        #1;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_error("write response never completed");
        end while (!(s_axi_bvalid && s_axi_bready));
    endtask

    task automatic read_reg(input logic [addr_w-1:0] addr, output logic [7:0] data);
        int waited;
        @(posedge clk);
        #1;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_error("read address never accepted");
        end while (!s_axi_arready);
        @(posedge clk);
        #1;
        s_axi_arvalid = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_error("read response never completed");
        end while (!(s_axi_rvalid && s_axi_rready));
        data = s_axi_rdata;
    endtask

    // Evaluated between edges where inputs and outputs are settled for the coming edge
    always @(negedge clk) begin : model_step
        logic       wr_hs;
        logic       rd_hs;
        logic       load;
        logic       hold;
        logic [1:0] exp_b;
        logic [7:0] exp_d;
        logic [1:0] exp_r;
        if (rst) begin
            model_state = state_init;
            model_ctrl  = ctrl_init;
            exp_bresp.delete();
            exp_rdata.delete();
            exp_rresp.delete();
        end else begin
            if (s_axi_bvalid && s_axi_bready) begin
                if (exp_bresp.size() == 0) begin
                    report_error("write response with no write outstanding");
                end else begin
                    exp_b = exp_bresp.pop_front();
                    assert (s_axi_bresp == exp_b)
                        else report_mismatch("s_axi_bresp", 8'(s_axi_bresp), 8'(exp_b));
                end
            end
            if (s_axi_rvalid && s_axi_rready) begin
                if (exp_rdata.size() == 0) begin
                    report_error("read response with no read outstanding");
                end else begin
                    exp_d = exp_rdata.pop_front();
                    exp_r = exp_rresp.pop_front();
                    assert (s_axi_rdata == exp_d)
                        else report_mismatch("s_axi_rdata", s_axi_rdata, exp_d);
                    assert (s_axi_rresp == exp_r)
                        else report_mismatch("s_axi_rresp", 8'(s_axi_rresp), 8'(exp_r));
                end
            end
            wr_hs = s_axi_awvalid && s_axi_wvalid && s_axi_awready && s_axi_wready;
            rd_hs = s_axi_arvalid && s_axi_arready;
            // Read data is the value before the edge
            if (rd_hs) begin
                if (s_axi_araddr == 4'h0) begin
                    exp_rdata.push_back(model_state);
                    exp_rresp.push_back(okay);
                end else if (s_axi_araddr == 4'h1) begin
                    exp_rdata.push_back({6'b0, model_ctrl});
                    exp_rresp.push_back(okay);
                end else begin
                    exp_rdata.push_back(8'h00);
                    exp_rresp.push_back(slverr);
                end
            end
            if (wr_hs) exp_bresp.push_back((s_axi_awaddr <= 4'h1) ? okay : slverr);
            load = wr_hs && (s_axi_awaddr == 4'h0) && s_axi_wstrb[0];
            hold = wr_hs && !load;
            // Step uses CTRL as it stood before this edge
            if (load) begin
                model_state = s_axi_wdata;
            end else if (!hold && model_ctrl[0]) begin
                model_state = model_ctrl[1] ? galois_step(model_state) : model_state ^ 8'h01;
            end
            if (wr_hs && (s_axi_awaddr == 4'h1) && s_axi_wstrb[0]) begin
                model_ctrl = s_axi_wdata[1:0];
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        streams_done  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (s_axi_awready == 1'b1)
            else report_mismatch("s_axi_awready", 8'(s_axi_awready), 8'h01);
        assert (s_axi_wready == 1'b1)
            else report_mismatch("s_axi_wready", 8'(s_axi_wready), 8'h01);
        assert (s_axi_arready == 1'b1)
            else report_mismatch("s_axi_arready", 8'(s_axi_arready), 8'h01);
        assert (s_axi_bvalid == 1'b0)
            else report_mismatch("s_axi_bvalid", 8'(s_axi_bvalid), 8'h00);
        assert (s_axi_rvalid == 1'b0)
            else report_mismatch("s_axi_rvalid", 8'(s_axi_rvalid), 8'h00);

        // Reset values and free-running toggle
        read_reg(4'h0, rd_val);
        read_reg(4'h1, rd_val);
        read_reg(4'h0, rd_val);

        // Seed load, then a write with the strobe clear
        write_reg(4'h0, 8'hA3, 1'b1);
        read_reg(4'h0, rd_val);
        read_reg(4'h0, rd_val);
        write_reg(4'h0, 8'h3C, 1'b0);
        read_reg(4'h0, rd_val);

        // LFSR from a zero seed
        write_reg(4'h1, 8'h03, 1'b1);
        write_reg(4'h0, 8'h00, 1'b1);
        repeat (8) read_reg(4'h0, rd_val);

        // Disabled generator holds its value
        write_reg(4'h1, 8'h02, 1'b1);
        read_reg(4'h0, rd_val);
        read_reg(4'h0, rd_val);

        // Holes in the map
        write_reg(4'h7, 8'hFF, 1'b1);
        read_reg(4'hC, rd_val);
        read_reg(4'h1, rd_val);
        read_reg(4'h0, rd_val);
        write_reg(4'h1, 8'h01, 1'b1);

        // Overlapping random traffic under back-pressure
        fork
            begin
                for (wr_count = 0; wr_count < rand_ops; wr_count++) begin
                    repeat (rand_byte() % 4) @(posedge clk);
                    wr_pick = pick_addr();
                    wr_val  = rand_byte();
                    wr_byte = rand_byte();
                    write_reg(wr_pick, wr_val, wr_byte[7:5] != 3'b000);
                end
                streams_done++;
            end
            begin
                for (rd_count = 0; rd_count < rand_ops; rd_count++) begin
                    repeat (rand_byte() % 3) @(posedge clk);
                    rd_pick = pick_addr();
                    read_reg(rd_pick, rd_val);
                end
                streams_done++;
            end
            begin
                bp_cycles = 0;
                while (streams_done < 2) begin
                    @(posedge clk);
                    #1;
                    bp_byte      = rand_byte();
                    s_axi_bready = bp_byte[0];
                    s_axi_rready = bp_byte[1];
                    bp_cycles++;
                    if (bp_cycles > 50000) report_error("random traffic did not finish");
                end
            end
        join
        s_axi_bready = 1'b1;
        s_axi_rready = 1'b1;
        repeat (4) @(negedge clk);

        if (exp_bresp.size() != 0 || exp_rdata.size() != 0) begin
            report_error("responses expected but never returned");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/rng_pkg.sv
source/axil_slave_port.sv
source/rng_regs.sv
source/rng_core.sv
source/rng_axil_top.sv
bench/rng_tb_assert.sv
bench/rng_tb.sv

//--- Makefile
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module rng_tb -f project.f --Mdir $(BUILD)
	./$(BUILD)/Vrng_tb | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
